/* Bender.yml */
package:
  name: spi_subsystem

sources:
  # Package first, then the RTL blocks bottom up
  - design/spi_pkg.sv
  - design/spi_clock_gen.sv
  - design/spi_shift_engine.sv
  - design/spi_wb_regs.sv
  - design/spi_target.sv
  - design/spi_subsystem_top.sv

  # Testbench, only for simulation
  - target: simulation
    files:
      - testbench/spi_tb.sv

/* design/spi_clock_gen.sv */
// SCLK half period tick generator for the SPI master
// Emits one tick every clk_div+1 cycles while enable is high
`timescale 1ns/100ps
`default_nettype none

module spi_clock_gen
  import spi_pkg::*;
(
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     enable,
  input  wire logic [CLK_DIV_WIDTH-1:0] clk_div,
  output logic                          tick
);

  // Counts down to zero, one tick per wrap
  logic [CLK_DIV_WIDTH-1:0] cnt;

  // ****************************************
  // Divider counter
  // ****************************************

  // While disabled the counter sits at the reload value
  // so the first half period after enable is full length
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!enable) begin
      cnt <= clk_div;
    end else if (cnt == '0) begin
      // Wrap and start the next half period
      cnt <= clk_div;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  // The tick marks the last cycle of each half period
  // and the engine acts on it at the following clk edge
  assign tick = enable && (cnt == '0);

endmodule

`default_nettype wire

/* design/spi_pkg.sv */
// Shared types and constants for the Wishbone controlled SPI subsystem
// Every RTL block imports this package for the config and bus structs
`default_nettype none

package spi_pkg;

  // ****************************************
  // Widths
  // ****************************************

  // Default SPI word width used by the top level
  localparam int unsigned DATA_WIDTH_DEF = 16;

  // Wishbone data bus and word address widths
  localparam int unsigned WB_DATA_WIDTH = 32;
  localparam int unsigned WB_ADDR_WIDTH = 3;

  // Width of the SCLK divider field
  localparam int unsigned CLK_DIV_WIDTH = 8;

  // Smallest divider that still leaves the target time to synchronise the pins
  localparam logic [CLK_DIV_WIDTH-1:0] CLK_DIV_MIN = 8'd3;

  // ****************************************
  // Register map
  // ****************************************

  localparam logic [WB_ADDR_WIDTH-1:0] REG_CTRL      = 3'd0;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_TXDATA    = 3'd1;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_RXDATA    = 3'd2;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_STATUS    = 3'd3;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_TARGET_RX = 3'd4;

  // Bit positions inside CTRL
  localparam int unsigned CTRL_CPOL_BIT   = 0;
  localparam int unsigned CTRL_CPHA_BIT   = 1;
  localparam int unsigned CTRL_INV_CS_BIT = 2;
  localparam int unsigned CTRL_DIV_LSB    = 8;

  // Bit positions inside STATUS
  localparam int unsigned STAT_BUSY_BIT      = 0;
  localparam int unsigned STAT_TGT_VALID_BIT = 1;

  // ****************************************
  // Structs
  // ****************************************

  // SPI mode and rate, shared by master and target
  typedef struct packed {
    logic [CLK_DIV_WIDTH-1:0] clk_div;  // Half period is clk_div+1 clk cycles
    logic                     inv_cs;   // Chip select is active high when set
    logic                     cpha;
    logic                     cpol;
  } spi_cfg_t;

  // Wishbone classic request from the bus master
  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [WB_ADDR_WIDTH-1:0] adr;
    logic [WB_DATA_WIDTH-1:0] dat;
  } wb_req_t;

  // Wishbone classic response, data is valid together with ack
  typedef struct packed {
    logic                     ack;
    logic [WB_DATA_WIDTH-1:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

/* design/spi_shift_engine.sv */
// SPI master transfer sequencer for single words, MSB first
// A start pulse runs setup, 2*DATA_WIDTH SCLK edges and hold, then done pulses
`timescale 1ns/100ps
`default_nettype none

module spi_shift_engine
  import spi_pkg::*;
#(
  parameter int unsigned DATA_WIDTH = DATA_WIDTH_DEF
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire spi_cfg_t              cfg,
  input  wire logic                  start,
  input  wire logic [DATA_WIDTH-1:0] tx_word,
  output logic                       busy,
  output logic                       done,
  output logic [DATA_WIDTH-1:0]      rx_word,
  output logic                       sclk,
  output logic                       mosi,
  input  wire logic                  miso,
  output logic                       cs
);

  // Edge counter covers 0 .. 2*DATA_WIDTH-1
  localparam int unsigned EDGE_W = $clog2(2 * DATA_WIDTH);
  localparam logic [EDGE_W-1:0] LAST_EDGE = EDGE_W'(2 * DATA_WIDTH - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_SHIFT,
    ST_HOLD
  } state_t;

  state_t              state;
  logic                tick;
  logic                sclk_ph;    // High while SCLK is away from its idle level
  logic                cs_active;
  logic [EDGE_W-1:0]   edge_cnt;
  logic [DATA_WIDTH-1:0] tx_sr;
  logic [DATA_WIDTH-1:0] rx_sr;
  logic                edge_now;
  logic                sample_en;
  logic                shift_en;

  spi_clock_gen clk_gen_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .enable  (busy),
    .clk_div (cfg.clk_div),
    .tick    (tick)
  );

  // ****************************************
  // Edge decode
  // ****************************************

  // Even edge counts are leading edges, odd ones are trailing
  assign edge_now = (state == ST_SHIFT) && tick;

  // CPHA 0 samples on leading edges and moves data on trailing edges
  // CPHA 1 moves data on every leading edge but the first and samples on trailing
  assign sample_en = edge_now && (cfg.cpha ? edge_cnt[0] : !edge_cnt[0]);
  assign shift_en  = edge_now &&
                     (cfg.cpha ? (!edge_cnt[0] && (edge_cnt != '0)) : edge_cnt[0]);

  // ****************************************
  // Sequencer
  // ****************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      sclk_ph   <= 1'b0;
      cs_active <= 1'b0;
      edge_cnt  <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state     <= ST_SETUP;
            cs_active <= 1'b1;
            edge_cnt  <= '0;
          end
        end
        // One half period with chip select asserted and MSB on MOSI
        ST_SETUP: begin
          if (tick) begin
            state <= ST_SHIFT;
          end
        end
        ST_SHIFT: begin
          if (tick) begin
            sclk_ph  <= !sclk_ph;
            edge_cnt <= edge_cnt + 1'b1;
            if (edge_cnt == LAST_EDGE) begin
              state <= ST_HOLD;
            end
          end
        end
        // One half period of hold before chip select drops
        ST_HOLD: begin
          if (tick) begin
            state     <= ST_IDLE;
            cs_active <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Data shift registers
  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && start) begin
      tx_sr <= tx_word;
    end else if (shift_en) begin
      tx_sr <= {tx_sr[DATA_WIDTH-2:0], 1'b0};
    end
    if (sample_en) begin
      rx_sr <= {rx_sr[DATA_WIDTH-2:0], miso};
    end
  end

  assign busy    = (state != ST_IDLE);
  // Done coincides with busy falling, so the received word is complete here
  assign done    = (state == ST_HOLD) && tick;
  assign rx_word = rx_sr;

  // Pin levels follow the configured polarity
  assign sclk = cfg.cpol ^ sclk_ph;
  assign cs   = !(cs_active ^ cfg.inv_cs);
  assign mosi = tx_sr[DATA_WIDTH-1];

endmodule

`default_nettype wire

/* design/spi_subsystem_top.sv */
// Top level of the SPI subsystem with a Wishbone port, master pins and slave pins
// The master and the on-chip target share one CTRL register for their mode
`timescale 1ns/100ps
`default_nettype none

module spi_subsystem_top
  import spi_pkg::*;
#(
  parameter int unsigned           DATA_WIDTH        = DATA_WIDTH_DEF,
  parameter logic [DATA_WIDTH-1:0] DEFAULT_MISO_DATA = 16'hcafe
) (
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire wb_req_t wb_req,
  output wb_rsp_t      wb_rsp,
  // Master port
  output logic         m_spi_sclk,
  output logic         m_spi_mosi,
  input  wire logic    m_spi_miso,
  output logic         m_spi_cs,
  // Slave port
  input  wire logic    s_spi_sclk,
  input  wire logic    s_spi_mosi,
  output logic         s_spi_miso,
  input  wire logic    s_spi_cs
);

  spi_cfg_t              cfg;
  logic                  start;
  logic [DATA_WIDTH-1:0] tx_word;
  logic                  busy;
  logic                  done;
  logic [DATA_WIDTH-1:0] rx_word;
  logic [DATA_WIDTH-1:0] target_word;
  logic                  target_done;

  spi_wb_regs #(
    .DATA_WIDTH (DATA_WIDTH)
  ) regs_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .cfg         (cfg),
    .start       (start),
    .tx_word     (tx_word),
    .busy        (busy),
    .rx_word     (rx_word),
    .done        (done),
    .target_word (target_word),
    .target_done (target_done)
  );

  // Host side master
  spi_shift_engine #(
    .DATA_WIDTH (DATA_WIDTH)
  ) engine_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg     (cfg),
    .start   (start),
    .tx_word (tx_word),
    .busy    (busy),
    .done    (done),
    .rx_word (rx_word),
    .sclk    (m_spi_sclk),
    .mosi    (m_spi_mosi),
    .miso    (m_spi_miso),
    .cs      (m_spi_cs)
  );

  // Slave that echoes the previous word
  spi_target #(
    .DATA_WIDTH        (DATA_WIDTH),
    .DEFAULT_MISO_DATA (DEFAULT_MISO_DATA)
  ) target_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg         (cfg),
    .sclk        (s_spi_sclk),
    .mosi        (s_spi_mosi),
    .cs          (s_spi_cs),
    .miso        (s_spi_miso),
    .target_word (target_word),
    .target_done (target_done)
  );

endmodule

`default_nettype wire

/* design/spi_target.sv */
// SPI slave sampled in the clk domain, mode taken from the shared CTRL register
// Replies with the previous received word, or DEFAULT_MISO_DATA before the first one
`timescale 1ns/100ps
`default_nettype none

module spi_target
  import spi_pkg::*;
#(
  parameter int unsigned           DATA_WIDTH        = DATA_WIDTH_DEF,
  parameter logic [DATA_WIDTH-1:0] DEFAULT_MISO_DATA = 'hcafe
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire spi_cfg_t         cfg,
  input  wire logic             sclk,
  input  wire logic             mosi,
  input  wire logic             cs,
  output logic                  miso,
  output logic [DATA_WIDTH-1:0] target_word,
  output logic                  target_done
);

  // The three slave inputs move through the synchroniser together
  typedef struct packed {
    logic sclk;
    logic mosi;
    logic cs;
  } spi_pins_t;

  spi_pins_t             pin_s1;
  spi_pins_t             pin_s2;
  logic                  sclk_q;
  logic                  cs_q;
  logic                  in_xfer;
  logic                  lead_seen;
  logic                  have_word;
  logic [DATA_WIDTH-1:0] tx_sr;
  logic [DATA_WIDTH-1:0] rx_sr;
  logic                  cs_act;
  logic                  cs_act_q;
  logic                  cs_assert;
  logic                  cs_release;
  logic                  sclk_edge;
  logic                  lead;
  logic                  trail;
  logic                  sample_en;
  logic                  shift_en;

  // ****************************************
  // Pin events
  // ****************************************

  // Chip select activity after optional inversion
  assign cs_act   = !(pin_s2.cs ^ cfg.inv_cs);
  assign cs_act_q = !(cs_q ^ cfg.inv_cs);

  // A polarity change in CTRL can look like a release, in_xfer filters that out
  assign cs_assert  = cs_act && !cs_act_q && !in_xfer;
  assign cs_release = in_xfer && !cs_act;

  // Leading edges leave the idle level, trailing edges return to it
  assign sclk_edge = in_xfer && cs_act && (pin_s2.sclk ^ sclk_q);
  assign lead      = sclk_edge && (pin_s2.sclk != cfg.cpol);
  assign trail     = sclk_edge && (pin_s2.sclk == cfg.cpol);

  // Same phase rule as the master, seen from the slave side
  assign sample_en = cfg.cpha ? trail : lead;
  assign shift_en  = cfg.cpha ? (lead && lead_seen) : trail;

  // ****************************************
  // Synchroniser and transfer control
  // ****************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pin_s1      <= '{sclk: 1'b0, mosi: 1'b0, cs: 1'b1};
      pin_s2      <= '{sclk: 1'b0, mosi: 1'b0, cs: 1'b1};
      sclk_q      <= 1'b0;
      cs_q        <= 1'b1;
      in_xfer     <= 1'b0;
      lead_seen   <= 1'b0;
      have_word   <= 1'b0;
      target_done <= 1'b0;
      tx_sr       <= DEFAULT_MISO_DATA;
    end else begin
      pin_s1      <= '{sclk: sclk, mosi: mosi, cs: cs};
      pin_s2      <= pin_s1;
      sclk_q      <= pin_s2.sclk;
      cs_q        <= pin_s2.cs;
      target_done <= cs_release;
      if (cs_assert) begin
        // Load the reply for this transfer
        in_xfer   <= 1'b1;
        lead_seen <= 1'b0;
        tx_sr     <= have_word ? target_word : DEFAULT_MISO_DATA;
      end else begin
        if (lead) begin
          lead_seen <= 1'b1;
        end
        if (shift_en) begin
          tx_sr <= {tx_sr[DATA_WIDTH-2:0], 1'b0};
        end
        if (cs_release) begin
          in_xfer   <= 1'b0;
          have_word <= 1'b1;
        end
      end
    end
  end

  // Received word, reported when chip select is released
  always_ff @(posedge clk) begin
    if (sample_en) begin
      rx_sr <= {rx_sr[DATA_WIDTH-2:0], pin_s2.mosi};
    end
    if (cs_release) begin
      target_word <= rx_sr;
    end
  end

  assign miso = tx_sr[DATA_WIDTH-1];

endmodule

`default_nettype wire

/* design/spi_wb_regs.sv */
// Wishbone classic register block for the SPI master and target
// Holds CTRL, launches transfers and captures received words for readback
`timescale 1ns/100ps
`default_nettype none

module spi_wb_regs
  import spi_pkg::*;
#(
  parameter int unsigned DATA_WIDTH = DATA_WIDTH_DEF
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire wb_req_t               wb_req,
  output wb_rsp_t                    wb_rsp,
  output spi_cfg_t                   cfg,
  output logic                       start,
  output logic [DATA_WIDTH-1:0]      tx_word,
  input  wire logic                  busy,
  input  wire logic [DATA_WIDTH-1:0] rx_word,
  input  wire logic                  done,
  input  wire logic [DATA_WIDTH-1:0] target_word,
  input  wire logic                  target_done
);

  logic                     ack_q;
  logic [WB_DATA_WIDTH-1:0] dat_q;
  logic [WB_DATA_WIDTH-1:0] rd_data;
  logic [DATA_WIDTH-1:0]    rx_data;
  logic [DATA_WIDTH-1:0]    target_rx;
  logic                     target_rx_valid;
  logic                     req_seen;
  logic                     wr_en;
  logic                     rd_en;
  logic                     idle;

  // A new request is one not yet acknowledged, which gives exactly one ack per cycle
  assign req_seen = wb_req.cyc && wb_req.stb && !ack_q;
  assign wr_en    = req_seen && wb_req.we;
  assign rd_en    = req_seen && !wb_req.we;

  // Writes to CTRL and TXDATA only take effect with no transfer in flight
  assign idle = !busy && !start;

  // ****************************************
  // Read mux
  // ****************************************

  always_comb begin
    rd_data = '0;
    case (wb_req.adr)
      REG_CTRL: begin
        rd_data[CTRL_CPOL_BIT]                     = cfg.cpol;
        rd_data[CTRL_CPHA_BIT]                     = cfg.cpha;
        rd_data[CTRL_INV_CS_BIT]                   = cfg.inv_cs;
        rd_data[CTRL_DIV_LSB +: CLK_DIV_WIDTH]     = cfg.clk_div;
      end
      REG_TXDATA:    rd_data = WB_DATA_WIDTH'(tx_word);
      REG_RXDATA:    rd_data = WB_DATA_WIDTH'(rx_data);
      REG_STATUS: begin
        rd_data[STAT_BUSY_BIT]      = busy;
        rd_data[STAT_TGT_VALID_BIT] = target_rx_valid;
      end
      REG_TARGET_RX: rd_data = WB_DATA_WIDTH'(target_rx);
      default:       rd_data = '0;
    endcase
  end

  // ****************************************
  // Control registers
  // ****************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q           <= 1'b0;
      start           <= 1'b0;
      cfg             <= '{clk_div: CLK_DIV_MIN, inv_cs: 1'b0, cpha: 1'b0, cpol: 1'b0};
      target_rx_valid <= 1'b0;
    end else begin
      ack_q <= req_seen;
      start <= wr_en && (wb_req.adr == REG_TXDATA) && idle;
      if (wr_en && (wb_req.adr == REG_CTRL) && idle) begin
        cfg.cpol   <= wb_req.dat[CTRL_CPOL_BIT];
        cfg.cpha   <= wb_req.dat[CTRL_CPHA_BIT];
        cfg.inv_cs <= wb_req.dat[CTRL_INV_CS_BIT];
        // Dividers below the minimum are raised to it
        if (wb_req.dat[CTRL_DIV_LSB +: CLK_DIV_WIDTH] < CLK_DIV_MIN) begin
          cfg.clk_div <= CLK_DIV_MIN;
        end else begin
          cfg.clk_div <= wb_req.dat[CTRL_DIV_LSB +: CLK_DIV_WIDTH];
        end
      end
      // A new target word wins over a clearing read in the same cycle
      if (target_done) begin
        target_rx_valid <= 1'b1;
      end else if (rd_en && (wb_req.adr == REG_TARGET_RX)) begin
        target_rx_valid <= 1'b0;
      end
    end
  end

  // Data registers
  always_ff @(posedge clk) begin
    dat_q <= rd_data;
    if (wr_en && (wb_req.adr == REG_TXDATA) && idle) begin
      tx_word <= wb_req.dat[DATA_WIDTH-1:0];
    end
    if (done) begin
      rx_data <= rx_word;
    end
    if (target_done) begin
      target_rx <= target_word;
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = dat_q;

endmodule

`default_nettype wire

/* sim.f */
design/spi_pkg.sv
design/spi_clock_gen.sv
design/spi_shift_engine.sv
design/spi_wb_regs.sv
design/spi_target.sv
design/spi_subsystem_top.sv
testbench/spi_tb.sv

/* testbench/spi_tb.sv */
// Testbench for the SPI subsystem with the master pins looped back to the target pins
// Runs Wishbone register cycles and checks replies, transfer length and idle pin levels
`timescale 1ns/100ps
`default_nettype none

module spi_tb
  import spi_pkg::*;
();

  localparam int unsigned   DW             = DATA_WIDTH_DEF;
  localparam logic [DW-1:0] DEFAULT_WORD   = 16'hcafe;
  localparam int unsigned   WORDS_PER_MODE = 8;
  // 39 transfers run with at most (2*DW+2)*7 cycles each plus register traffic
  localparam int unsigned   NUM_XFERS      = 40;
  localparam int unsigned   MAX_CYCLES     = NUM_XFERS * (2 * DW + 2) * 7 + 2000;

  logic        clk;
  logic        rst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        m_spi_sclk;
  logic        m_spi_mosi;
  logic        m_spi_cs;
  logic        s_spi_miso;
  int unsigned cycle_count;

  // Mode currently programmed and the history the reply model needs
  logic          cur_cpol;
  logic          cur_cpha;
  logic          cur_inv_cs;
  logic [7:0]    cur_div;
  bit            have_prev;
  logic [DW-1:0] prev_word;

  // Master pins feed the slave pins so the master talks to the on-chip target
  spi_subsystem_top #(
    .DATA_WIDTH        (DW),
    .DEFAULT_MISO_DATA (DEFAULT_WORD)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .m_spi_sclk (m_spi_sclk),
    .m_spi_mosi (m_spi_mosi),
    .m_spi_miso (s_spi_miso),
    .m_spi_cs   (m_spi_cs),
    .s_spi_sclk (m_spi_sclk),
    .s_spi_mosi (m_spi_mosi),
    .s_spi_miso (s_spi_miso),
    .s_spi_cs   (m_spi_cs)
  );

  always #10 clk = !clk;

  // Cycle limit so a stuck transfer cannot hang the run
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("ERROR: run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $fatal(1, "Timeout");
    end
  end

  // ****************************************
  // Reference model and checks
  // ****************************************

  // The target echoes the previous word and sends the default word before any word arrived
  function automatic logic [DW-1:0] expected_reply(input bit prev_valid,
                                                   input logic [DW-1:0] prev);
    if (prev_valid) begin
      return prev;
    end
    return DEFAULT_WORD;
  endfunction

  // CTRL has cpol in bit 0, cpha in bit 1, inv_cs in bit 2 and the divider in bits 15:8
  function automatic logic [31:0] ctrl_word(input logic cpol, input logic cpha,
                                            input logic inv_cs, input logic [7:0] div);
    return {16'h0000, div, 5'b00000, inv_cs, cpha, cpol};
  endfunction

  task automatic stop_run(input string why);
    $display("ERROR: %s", why);
    $display("Result: FAILED");
    $fatal(1, "Run stopped after an error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // ****************************************
  // Wishbone classic bus tasks
  // ****************************************

  task automatic wb_write(input logic [WB_ADDR_WIDTH-1:0] adr,
                          input logic [WB_DATA_WIDTH-1:0] dat);
    int unsigned waited;
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_rsp.ack && waited < 4);
    if (!wb_rsp.ack) begin
      stop_run($sformatf("no ack within 4 cycles for a write to register %0d", adr));
    end
    wb_req = '0;
  endtask

  task automatic wb_read(input logic [WB_ADDR_WIDTH-1:0] adr,
                         output logic [WB_DATA_WIDTH-1:0] dat);
    int unsigned waited;
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_rsp.ack && waited < 4);
    if (!wb_rsp.ack) begin
      stop_run($sformatf("no ack within 4 cycles for a read of register %0d", adr));
    end
    // Read data is valid together with ack
    dat    = wb_rsp.dat;
    wb_req = '0;
  endtask

  // ****************************************
  // Transfer helpers
  // ****************************************

  // Idle SCLK sits at cpol and idle chip select is high unless inverted
  task automatic check_idle_pins();
    check_equal("m_spi_sclk", m_spi_sclk, cur_cpol);
    check_equal("m_spi_cs", m_spi_cs, !cur_inv_cs);
  endtask

  task automatic set_ctrl(input logic cpol, input logic cpha, input logic inv_cs,
                          input logic [7:0] div);
    logic [31:0] rdata;
    cur_cpol   = cpol;
    cur_cpha   = cpha;
    cur_inv_cs = inv_cs;
    cur_div    = div;
    wb_write(REG_CTRL, ctrl_word(cpol, cpha, inv_cs, div));
    wb_read(REG_CTRL, rdata);
    check_equal("ctrl", rdata, ctrl_word(cpol, cpha, inv_cs, div));
    check_idle_pins();
  endtask

  // Reads back both received words once busy has fallen
  task automatic finish_transfer(input logic [DW-1:0] sent);
    logic [31:0] rdata;
    int unsigned polls;
    wb_read(REG_RXDATA, rdata);
    check_equal("rxdata", rdata, expected_reply(have_prev, prev_word));
    // The target reports a few cycles after chip select is released
    polls = 0;
    rdata = '0;
    while (!rdata[STAT_TGT_VALID_BIT] && polls < 8) begin
      wb_read(REG_STATUS, rdata);
      polls++;
    end
    if (!rdata[STAT_TGT_VALID_BIT]) begin
      stop_run("target_rx_valid was not set after the transfer ended");
    end
    wb_read(REG_TARGET_RX, rdata);
    check_equal("target_rx", rdata, sent);
    // Reading TARGET_RX clears the valid flag
    wb_read(REG_STATUS, rdata);
    check_equal("status", rdata, 32'h0);
    have_prev = 1'b1;
    prev_word = sent;
  endtask

  task automatic run_transfer(input logic [DW-1:0] word);
    int unsigned busy_cycles;
    wb_write(REG_TXDATA, word);
    check_equal("busy_at_ack", dut_i.busy, 1'b0);
    @(negedge clk);
    check_equal("busy_after_ack", dut_i.busy, 1'b1);
    // Chip select is active and the MSB already leads the first SCLK edge
    check_equal("m_spi_cs", m_spi_cs, cur_inv_cs);
    check_equal("m_spi_mosi", m_spi_mosi, word[DW-1]);
    busy_cycles = 0;
    while (dut_i.busy) begin
      busy_cycles++;
      @(negedge clk);
    end
    // Setup and hold add one half period each to the 2*DW SCLK half periods
    check_equal("busy_cycles", busy_cycles, (2 * DW + 2) * (cur_div + 1));
    check_idle_pins();
    finish_transfer(word);
  endtask

  // ****************************************
  // Test sequence
  // ****************************************

  initial begin : main_seq
    logic [31:0]   rdata;
    logic [DW-1:0] w_first;
    int unsigned   mode;
    int unsigned   seed;
    clk         = 1'b0;
    rst_n       = 1'b0;
    wb_req      = '0;
    cycle_count = 0;
    have_prev   = 1'b0;
    prev_word   = '0;
    cur_cpol    = 1'b0;
    cur_cpha    = 1'b0;
    cur_inv_cs  = 1'b0;
    cur_div     = CLK_DIV_MIN;
    seed        = 32'hd2fd_b869;
    void'($urandom(seed));
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    // Reset state first and then the default word as the first reply
    check_idle_pins();
    check_equal("s_spi_miso", s_spi_miso, DEFAULT_WORD[DW-1]);
    wb_read(REG_STATUS, rdata);
    check_equal("status", rdata, 32'h0);
    run_transfer(DW'($urandom()));

    // All four CPOL/CPHA modes with a random divider each
    for (mode = 0; mode < 4; mode++) begin
      set_ctrl(mode[0], mode[1], 1'b0, 8'($urandom_range(6, 3)));
      repeat (WORDS_PER_MODE) run_transfer(DW'($urandom()));
    end

    // Active high chip select
    mode = $urandom_range(3);
    set_ctrl(mode[0], mode[1], 1'b1, 8'($urandom_range(6, 3)));
    repeat (4) run_transfer(DW'($urandom()));

    // The second word and the CTRL change arrive while busy and are both dropped
    set_ctrl(1'b0, 1'b1, 1'b0, 8'($urandom_range(6, 3)));
    w_first = DW'($urandom());
    wb_write(REG_TXDATA, w_first);
    wb_write(REG_TXDATA, ~w_first);
    wb_write(REG_CTRL, 32'h0000_0f07);
    while (dut_i.busy) @(negedge clk);
    wb_read(REG_CTRL, rdata);
    check_equal("ctrl", rdata, ctrl_word(cur_cpol, cur_cpha, cur_inv_cs, cur_div));
    wb_read(REG_TXDATA, rdata);
    check_equal("txdata", rdata, w_first);
    check_idle_pins();
    finish_transfer(w_first);
    // The target must now answer with the first word only
    run_transfer(DW'($urandom()));

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
